//--- mem_types_pkg.sv
package mem_types_pkg;

    // line geometry
    localparam int line_bytes_c  = 32;
    localparam int line_words_c  = 8;
    localparam int num_sets_c    = 8;

    // address split: tag | index | offset
    localparam int offset_bits_c = 5;
    localparam int index_bits_c  = 3;
    localparam int tag_bits_c    = 24;

    // 64-bit bursts per line
    localparam int beats_c       = 4;

    // one cache line, seen as a flat vector or as words
    typedef union packed {
        logic [line_bytes_c*8-1:0]      flat;   // arbiter and adaptor side
        logic [line_words_c-1:0][31:0]  words;  // word select / merge in the caches
    } cacheline_t;

endpackage : mem_types_pkg

//--- l1_cache.sv
`timescale 1ns/10ps

module l1_cache #(
    parameter bit writable_p = 1'b0
) (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // word side, towards the cpu
    input  logic [31:0]               addr_i,
    input  logic                      read_i,
    input  logic                      write_i,
    input  logic [3:0]                wmask_i,
    input  logic [31:0]               wdata_i,
    output logic [31:0]               rdata_o,
    output logic                      resp_o,

    // line side, towards the arbiter
    output logic [31:0]               line_addr_o,
    output logic                      line_read_o,
    output logic                      line_write_o,
    input  mem_types_pkg::cacheline_t line_rdata_i,
    output mem_types_pkg::cacheline_t line_wdata_o,
    input  logic                      line_resp_i
);
    import mem_types_pkg::*;

    logic [tag_bits_c-1:0]    addr_tag;
    logic [index_bits_c-1:0]  addr_index;
    logic [offset_bits_c-3:0] word_sel;

    logic                     req;
    logic                     hit;
    logic                     fill_done;
    logic                     victim_dirty;
    logic                     wr_hit;
    logic [31:0]              merged_word;

    logic                     wb_q;     // writing the victim back
    logic                     fill_q;   // waiting for the new line
    logic                     resp_q;
    logic [31:0]              rdata_q;

    logic [num_sets_c-1:0]    valid_q;
    logic [tag_bits_c-1:0]    tag_q  [num_sets_c];
    cacheline_t               data_q [num_sets_c];
    cacheline_t               cur_line;

    assign addr_tag   = addr_i[31 -: tag_bits_c];
    assign addr_index = addr_i[offset_bits_c +: index_bits_c];
    assign word_sel   = addr_i[offset_bits_c-1:2];

    assign cur_line  = data_q[addr_index];
    assign hit       = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);
    // compare only when idle, and not in the cycle resp is shown
    assign req       = (read_i || write_i) && !wb_q && !fill_q && !resp_q;
    assign fill_done = fill_q && line_resp_i;

    if (writable_p) begin : g_write
        logic [num_sets_c-1:0] dirty_q;

        always_comb begin
            merged_word = cur_line.words[word_sel];
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) merged_word[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end

        assign wr_hit       = req && hit && write_i;
        assign victim_dirty = valid_q[addr_index] && dirty_q[addr_index];

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                dirty_q <= '0;
            end else if (fill_done) begin
                dirty_q[addr_index] <= 1'b0;    // fresh line from memory
            end else if (wr_hit) begin
                dirty_q[addr_index] <= 1'b1;
            end
        end
    end else begin : g_read_only
        assign merged_word  = cur_line.words[word_sel];
        assign wr_hit       = 1'b0;
        assign victim_dirty = 1'b0;
    end

    // compare -> (write-back) -> fill -> compare again, which then hits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q   <= 1'b0;
            fill_q <= 1'b0;
            resp_q <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            if (wb_q) begin
                if (line_resp_i) begin
                    wb_q   <= 1'b0;
                    fill_q <= 1'b1;
                end
            end else if (fill_q) begin
                if (line_resp_i) fill_q <= 1'b0;
            end else if (req) begin
                if (hit)               resp_q <= 1'b1;
                else if (victim_dirty) wb_q   <= 1'b1;
                else                   fill_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) valid_q <= '0;
        else if (fill_done) valid_q[addr_index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q[addr_index]  <= addr_tag;
            data_q[addr_index] <= line_rdata_i;
        end else if (wr_hit) begin
            data_q[addr_index].words[word_sel] <= merged_word;
        end
        if (req && hit) rdata_q <= cur_line.words[word_sel];
    end

    assign rdata_o      = rdata_q;
    assign resp_o       = resp_q;
    assign line_read_o  = fill_q;
    assign line_write_o = wb_q;
    assign line_wdata_o = cur_line;     // victim line during write-back
    assign line_addr_o  = wb_q ? {tag_q[addr_index], addr_index, {offset_bits_c{1'b0}}}
                               : {addr_tag, addr_index, {offset_bits_c{1'b0}}};

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(read_i && write_i))
        else $error("l1_cache: read and write requested together");

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (read_i || write_i) && !resp_o |=> $stable(addr_i))
        else $error("l1_cache: address changed while a request was waiting");

endmodule : l1_cache

//--- cache_arbiter.sv
`timescale 1ns/10ps

module cache_arbiter (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // icache, read only
    input  logic [31:0]               ic_addr_i,
    input  logic                      ic_read_i,
    output mem_types_pkg::cacheline_t ic_rdata_o,
    output logic                      ic_resp_o,

    // dcache
    input  logic [31:0]               dc_addr_i,
    input  logic                      dc_read_i,
    input  logic                      dc_write_i,
    input  mem_types_pkg::cacheline_t dc_wdata_i,
    output mem_types_pkg::cacheline_t dc_rdata_o,
    output logic                      dc_resp_o,

    // shared line port
    output logic [31:0]               mem_addr_o,
    output logic                      mem_read_o,
    output logic                      mem_write_o,
    output mem_types_pkg::cacheline_t mem_wdata_o,
    input  mem_types_pkg::cacheline_t mem_rdata_i,
    input  logic                      mem_resp_i
);
    import mem_types_pkg::*;

    logic grant_ic_q;   // both low means idle
    logic grant_dc_q;
    logic dc_req;

    assign dc_req = dc_read_i || dc_write_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant_ic_q <= 1'b0;
            grant_dc_q <= 1'b0;
        end else if (grant_ic_q || grant_dc_q) begin
            if (mem_resp_i) begin       // hold grant until the line comes back
                grant_ic_q <= 1'b0;
                grant_dc_q <= 1'b0;
            end
        end else if (dc_req) begin
            grant_dc_q <= 1'b1;         // dcache has priority
        end else if (ic_read_i) begin
            grant_ic_q <= 1'b1;
        end
    end

    assign mem_addr_o  = grant_dc_q ? dc_addr_i : ic_addr_i;
    assign mem_read_o  = (grant_dc_q && dc_read_i) || (grant_ic_q && ic_read_i);
    assign mem_write_o = grant_dc_q && dc_write_i;
    assign mem_wdata_o = dc_wdata_i;

    // data goes to both, resp only to the owner
    assign ic_rdata_o = mem_rdata_i;
    assign dc_rdata_o = mem_rdata_i;
    assign ic_resp_o  = grant_ic_q && mem_resp_i;
    assign dc_resp_o  = grant_dc_q && mem_resp_i;

    // a line response belongs to exactly one cache
    a_one_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_resp_i |-> (ic_resp_o != dc_resp_o))
        else $error("cache_arbiter: line response did not reach exactly one cache");

endmodule : cache_arbiter

//--- cacheline_adaptor.sv
`timescale 1ns/10ps

module cacheline_adaptor (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // line side
    input  logic [31:0]               line_addr_i,
    input  logic                      line_read_i,
    input  logic                      line_write_i,
    input  mem_types_pkg::cacheline_t line_wdata_i,
    output mem_types_pkg::cacheline_t line_rdata_o,
    output logic                      line_resp_o,

    // burst side, towards memory
    input  logic [63:0]               burst_rdata_i,
    output logic [63:0]               burst_wdata_o,
    output logic [31:0]               burst_addr_o,
    output logic                      burst_read_o,
    output logic                      burst_write_o,
    input  logic                      burst_resp_i
);
    import mem_types_pkg::*;

    logic                       busy_q;     // transfer in progress
    logic                       done_q;     // line resp cycle
    logic [$clog2(beats_c)-1:0] beat_q;
    logic                       last_beat;
    cacheline_t                 buf_q;

    assign last_beat = burst_resp_i && (beat_q == beats_c - 1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            beat_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (busy_q) begin
                if (burst_resp_i) beat_q <= beat_q + 1'b1;
                if (last_beat) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;     // resp one cycle after beat 4
                end
            end else if ((line_read_i || line_write_i) && !done_q) begin
                busy_q <= 1'b1;
                beat_q <= '0;
            end
        end
    end

    // gather read beats, lowest first
    always_ff @(posedge clk) begin
        if (busy_q && line_read_i && burst_resp_i) begin
            buf_q.flat[64*beat_q +: 64] <= burst_rdata_i;
        end
    end

    assign burst_addr_o  = line_addr_i;
    assign burst_read_o  = busy_q && line_read_i;
    assign burst_write_o = busy_q && line_write_i;
    assign burst_wdata_o = line_wdata_i.flat[64*beat_q +: 64];

    assign line_rdata_o  = buf_q;
    assign line_resp_o   = done_q;

    a_resp_in_xfer: assert property (@(posedge clk) disable iff (!rst_n_i)
        burst_resp_i |-> busy_q)
        else $error("cacheline_adaptor: memory answered with no transfer active");

endmodule : cacheline_adaptor

//--- mem_hier_top.sv
`timescale 1ns/10ps

module mem_hier_top (
    input  logic        clk,
    input  logic        rst_n_i,

    // instruction fetch port
    input  logic [31:0] imem_addr_i,
    input  logic        imem_read_i,
    output logic [31:0] imem_rdata_o,
    output logic        imem_resp_o,

    // load/store port
    input  logic [31:0] dmem_addr_i,
    input  logic        dmem_read_i,
    input  logic        dmem_write_i,
    input  logic [3:0]  dmem_wmask_i,
    input  logic [31:0] dmem_wdata_i,
    output logic [31:0] dmem_rdata_o,
    output logic        dmem_resp_o,

    // burst memory
    output logic [31:0] bmem_address_o,
    output logic        bmem_read_o,
    output logic        bmem_write_o,
    output logic [63:0] bmem_wdata_o,
    input  logic [63:0] bmem_rdata_i,
    input  logic        bmem_resp_i
);
    import mem_types_pkg::*;

    // icache <-> arbiter
    logic [31:0] ic_line_addr;
    logic        ic_line_read;
    cacheline_t  ic_line_rdata;
    logic        ic_line_resp;

    // dcache <-> arbiter
    logic [31:0] dc_line_addr;
    logic        dc_line_read, dc_line_write;
    cacheline_t  dc_line_rdata, dc_line_wdata;
    logic        dc_line_resp;

    // arbiter <-> adaptor
    logic [31:0] mem_line_addr;
    logic        mem_line_read, mem_line_write;
    cacheline_t  mem_line_rdata, mem_line_wdata;
    logic        mem_line_resp;

    l1_cache #(.writable_p(1'b0)) i_icache (
        .clk(clk), .rst_n_i(rst_n_i),
        .addr_i(imem_addr_i), .read_i(imem_read_i), .write_i(1'b0),
        .wmask_i(4'h0), .wdata_i(32'h0),    // fetch side never writes
        .rdata_o(imem_rdata_o), .resp_o(imem_resp_o),
        .line_addr_o(ic_line_addr), .line_read_o(ic_line_read), .line_write_o(),
        .line_rdata_i(ic_line_rdata), .line_wdata_o(), .line_resp_i(ic_line_resp)
    );

    l1_cache #(.writable_p(1'b1)) i_dcache (
        .clk(clk), .rst_n_i(rst_n_i),
        .addr_i(dmem_addr_i), .read_i(dmem_read_i), .write_i(dmem_write_i),
        .wmask_i(dmem_wmask_i), .wdata_i(dmem_wdata_i),
        .rdata_o(dmem_rdata_o), .resp_o(dmem_resp_o),
        .line_addr_o(dc_line_addr), .line_read_o(dc_line_read),
        .line_write_o(dc_line_write), .line_rdata_i(dc_line_rdata),
        .line_wdata_o(dc_line_wdata), .line_resp_i(dc_line_resp)
    );

    cache_arbiter i_arbiter (
        .clk(clk), .rst_n_i(rst_n_i),
        .ic_addr_i(ic_line_addr), .ic_read_i(ic_line_read),
        .ic_rdata_o(ic_line_rdata), .ic_resp_o(ic_line_resp),
        .dc_addr_i(dc_line_addr), .dc_read_i(dc_line_read), .dc_write_i(dc_line_write),
        .dc_wdata_i(dc_line_wdata), .dc_rdata_o(dc_line_rdata), .dc_resp_o(dc_line_resp),
        .mem_addr_o(mem_line_addr), .mem_read_o(mem_line_read),
        .mem_write_o(mem_line_write), .mem_wdata_o(mem_line_wdata),
        .mem_rdata_i(mem_line_rdata), .mem_resp_i(mem_line_resp)
    );

    cacheline_adaptor i_adaptor (
        .clk(clk), .rst_n_i(rst_n_i),
        .line_addr_i(mem_line_addr), .line_read_i(mem_line_read),
        .line_write_i(mem_line_write), .line_wdata_i(mem_line_wdata),
        .line_rdata_o(mem_line_rdata), .line_resp_o(mem_line_resp),
        .burst_rdata_i(bmem_rdata_i), .burst_wdata_o(bmem_wdata_o),
        .burst_addr_o(bmem_address_o), .burst_read_o(bmem_read_o),
        .burst_write_o(bmem_write_o), .burst_resp_i(bmem_resp_i)
    );

endmodule : mem_hier_top

//--- bmem_model.sv
`timescale 1ns/10ps

module bmem_model (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] address_i,
    input  logic        read_i,
    input  logic        write_i,
    input  logic [63:0] wdata_i,
    output logic [63:0] rdata_o,
    output logic        resp_o
);
    import mem_types_pkg::*;

    localparam int latency_c = 4;       // cycles before the first beat

    logic [63:0] mem [logic [31:0]];    // written beats only, keyed by beat address
    int          cnt_q;

    // untouched memory follows the fill rule, low word at the lower address
    function automatic logic [63:0] beat_at(input logic [31:0] a);
        if (mem.exists(a)) return mem[a];
        return {(a + 32'd4) ^ 32'hA5A5_0000, a ^ 32'hA5A5_0000};
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q   <= 0;
            resp_o  <= 1'b0;
            rdata_o <= '0;
        end else begin
            resp_o <= 1'b0;
            if (!(read_i || write_i)) begin
                cnt_q <= 0;
            end else begin
                // a write beat is taken in the cycle its resp is high
                if (resp_o && write_i) begin
                    mem[address_i + 32'(8 * (cnt_q - latency_c - 1))] = wdata_i;
                end
                if (cnt_q < latency_c + beats_c) begin
                    cnt_q <= cnt_q + 1;
                    if (cnt_q >= latency_c) begin
                        resp_o  <= 1'b1;
                        rdata_o <= beat_at(address_i + 32'(8 * (cnt_q - latency_c)));
                    end
                end
            end
        end
    end

endmodule : bmem_model

//--- tb_mem_hier.sv
`timescale 1ns/10ps

module tb_mem_hier;
    localparam int num_req_c = 25;  // requests issued by the stimulus below

    logic        clk;
    logic        rst_n_i;
    logic [31:0] imem_addr_i;
    logic        imem_read_i;
    logic [31:0] imem_rdata_o;
    logic        imem_resp_o;
    logic [31:0] dmem_addr_i;
    logic        dmem_read_i;
    logic        dmem_write_i;
    logic [3:0]  dmem_wmask_i;
    logic [31:0] dmem_wdata_i;
    logic [31:0] dmem_rdata_o;
    logic        dmem_resp_o;
    logic [31:0] bmem_address_o;
    logic        bmem_read_o;
    logic        bmem_write_o;
    logic [63:0] bmem_wdata_o;
    logic [63:0] bmem_rdata_i;
    logic        bmem_resp_i;

    logic [31:0] imem_exp;
    logic [31:0] dmem_exp;
    logic        expect_hit;            // next request must hit
    logic        expect_wb;             // next load must evict a dirty line
    int          wb_count;
    int          wb_mark;
    logic [31:0] ref_mem [logic [31:0]];

    mem_hier_top i_dut (.*);

    bmem_model i_bmem (
        .clk(clk), .rst_n_i(rst_n_i),
        .address_i(bmem_address_o), .read_i(bmem_read_o), .write_i(bmem_write_o),
        .wdata_i(bmem_wdata_o), .rdata_o(bmem_rdata_i), .resp_o(bmem_resp_i)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (bmem_write_o) wb_count <= wb_count + 1;    // cycles with a burst write open
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_run($sformatf("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    function automatic logic [31:0] rule_word(input logic [31:0] a);
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return rule_word(a);
    endfunction

    // every request starts 2 ns after an edge and ends with one idle cycle
    task automatic fetch_word(input logic [31:0] addr);
        imem_exp    = rule_word(addr);
        imem_addr_i = addr;
        imem_read_i = 1'b1;
        do @(negedge clk); while (!imem_resp_o);
        @(posedge clk);
        #2 imem_read_i = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic load_word(input logic [31:0] addr);
        dmem_exp    = ref_word(addr);
        dmem_addr_i = addr;
        dmem_read_i = 1'b1;
        do @(negedge clk); while (!dmem_resp_o);
        @(posedge clk);
        #2 dmem_read_i = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
        logic [31:0] merged;
        merged = ref_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) merged[8*b +: 8] = data[8*b +: 8];
        end
        ref_mem[addr] = merged;
        dmem_addr_i   = addr;
        dmem_wdata_i  = data;
        dmem_wmask_i  = mask;
        dmem_write_i  = 1'b1;
        do @(negedge clk); while (!dmem_resp_o);
        @(posedge clk);
        #2 dmem_write_i = 1'b0;
        @(posedge clk);
        #2;
    endtask

    a_quiet_reset: assert property (@(posedge clk) (!rst_n_i || !$past(rst_n_i)) |->
        !(imem_resp_o || dmem_resp_o || bmem_read_o || bmem_write_o))
        else fail_run("a resp, read or write output was active during or right after reset");

    a_imem_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        imem_resp_o |-> imem_rdata_o == imem_exp)
        else report_mismatch("imem_rdata_o", $sampled(imem_exp), $sampled(imem_rdata_o));

    a_dmem_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_resp_o && dmem_read_i |-> dmem_rdata_o == dmem_exp)
        else report_mismatch("dmem_rdata_o", $sampled(dmem_exp), $sampled(dmem_rdata_o));

    a_imem_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(imem_read_i) && expect_hit |=> imem_resp_o)
        else fail_run("fetch of a cached line did not respond one cycle after the request");

    a_dmem_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(dmem_read_i) && expect_hit |=> dmem_resp_o)
        else fail_run("load of a cached line did not respond one cycle after the request");

    a_write_back: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_resp_o && expect_wb |-> wb_count != wb_mark)
        else fail_run("conflicting load finished without writing the dirty line back");

    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        (bmem_read_o || bmem_write_o) |-> bmem_address_o[4:0] == 5'h0)
        else fail_run("burst address on the memory bus is not line aligned");

    initial begin
        logic [31:0] addr;
        void'($urandom(32'h24f8));
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        imem_addr_i  = '0;
        imem_read_i  = 1'b0;
        dmem_addr_i  = '0;
        dmem_read_i  = 1'b0;
        dmem_write_i = 1'b0;
        dmem_wmask_i = '0;
        dmem_wdata_i = '0;
        imem_exp     = '0;
        dmem_exp     = '0;
        expect_hit   = 1'b0;
        expect_wb    = 1'b0;
        wb_count     = 0;
        wb_mark      = 0;
        addr         = '0;
        repeat (5) @(posedge clk);
        #2 rst_n_i = 1'b1;
        @(posedge clk);
        #2;

        for (int i = 0; i < 8; i++) begin     // code region 0x0000_0xxx
            addr = $urandom & 32'h0000_0ffc;
            fetch_word(addr);
        end
        expect_hit = 1'b1;
        fetch_word(addr);
        expect_hit = 1'b0;

        for (int i = 0; i < 4; i++) begin     // data region 0x0001_0xxx
            addr = 32'h0001_0000 | ($urandom & 32'h0000_0ffc);
            store_word(addr, $urandom, 4'($urandom));
            load_word(addr);
        end
        expect_hit = 1'b1;
        load_word(addr);
        expect_hit = 1'b0;

        // same index 2, different tag
        store_word(32'h0002_0040, $urandom, 4'b1101);
        expect_wb = 1'b1;
        wb_mark   = wb_count;
        load_word(32'h0002_0140);
        expect_wb = 1'b0;
        load_word(32'h0002_0040);     // data must come back from memory

        fork
            fetch_word(32'h0000_2004);
            load_word(32'h0003_0008);
        join
        fork
            fetch_word(32'h0000_2f3c);
            load_word(32'h0003_01a0);
        join

        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat (num_req_c * 200 + 10) @(posedge clk);
        fail_run("watchdog expired, a request never got its response");
    end

endmodule : tb_mem_hier

//--- build.f
mem_types_pkg.sv
l1_cache.sv
cache_arbiter.sv
cacheline_adaptor.sv
mem_hier_top.sv
bmem_model.sv
tb_mem_hier.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_mem_hier
RTL_TOP   := mem_hier_top
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
